// File: flist.f
source/apb_subsys_pkg.sv
source/ahb_apb_ctrl.sv
source/endian_swap.sv
source/apb_slot_mux.sv
source/irq_collect.sv
source/apb_subsys_top.sv
sim/apb_subsys_chk.sv
sim/tb_apb_subsys.sv

// File: sim/apb_subsys_chk.sv
// Concurrent protocol assertions for the AHB to APB phase controller, attached to it with bind
`timescale 1ns/1ps

module apb_subsys_chk
(
  input logic HCLK,
  input logic HRESETn,
  input logic i_psel,
  input logic i_penable,
  input logic i_hresp,
  input logic i_hreadyout
);

  int fail_count = 0;

  // ----------------------------------------------------------
  // APB phase rules
  // ----------------------------------------------------------
  property p_penable_in_psel;
    @(posedge HCLK) disable iff (!HRESETn) i_penable |-> i_psel;
  endproperty

  property p_setup_to_access;  // Setup lasts one cycle
    @(posedge HCLK) disable iff (!HRESETn) (i_psel && !i_penable) |=> i_penable;
  endproperty

  // Two-cycle AHB error response starts with the bus stalled
  property p_err_first_cycle;
    @(posedge HCLK) disable iff (!HRESETn) $rose(i_hresp) |-> !i_hreadyout;
  endproperty

  a_penable_in_psel: assert property (p_penable_in_psel)
  else
  begin
    $error("PENABLE high while PSEL is low");
    fail_count++;
  end

  a_setup_to_access: assert property (p_setup_to_access)
  else
  begin
    $error("Setup cycle not followed by PENABLE");
    fail_count++;
  end

  a_err_first_cycle: assert property (p_err_first_cycle)
  else
  begin
    $error("First HRESP cycle had HREADYOUT high");
    fail_count++;
  end

endmodule

bind ahb_apb_ctrl apb_subsys_chk apb_subsys_chk_i (
  .HCLK        (HCLK),
  .HRESETn     (HRESETn),
  .i_psel      (o_psel_any),
  .i_penable   (o_req.penable),
  .i_hresp     (o_hresp),
  .i_hreadyout (o_hreadyout)
);

// File: sim/tb_apb_subsys.sv
// Testbench driving random AHB transfers and interrupts into the APB subsystem against a model
`timescale 1ns/1ps

module tb_apb_subsys
  import apb_subsys_pkg::*;
();

  logic                 HCLK;
  logic                 HRESETn;
  logic                 hsel;
  logic [AHB_AW-1:0]    haddr;
  logic [1:0]           htrans;
  logic                 hwrite;
  logic [2:0]           hsize;
  logic                 hready;
  logic [DW-1:0]        hwdata;
  logic                 hreadyout;
  logic [DW-1:0]        hrdata;
  logic                 hresp;
  logic                 big_endian;
  apb_req_t             apb;
  logic [N_EXT-1:0]     ext_psel;
  apb_rsp_t [N_EXT-1:0] ext_rsp;
  logic                 apbactive;
  irq_src_t             irq_src;
  logic [IRQ_W-1:0]     irq;
  logic                 wdog_int;
  logic                 wdog_rst;

  logic [31:0] rng_state = 32'had77;
  logic [31:0] slv_mem [0:63];  // Slave storage indexed by {slot, paddr[5:2]}
  logic [31:0] ref_mem [0:63];  // Expected contents
  int          wait_left [0:N_EXT-1];
  int          plan_waits;      // Wait states for the next access
  logic        plan_err;
  int          checks = 0;
  int          errors = 0;

  apb_subsys_top apb_subsys_top_i (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .i_hsel (hsel), .i_haddr (haddr), .i_htrans (htrans), .i_hwrite (hwrite),
    .i_hsize (hsize), .i_hready (hready), .i_hwdata (hwdata),
    .o_hreadyout (hreadyout), .o_hrdata (hrdata), .o_hresp (hresp),
    .i_big_endian (big_endian), .o_apb (apb), .o_ext_psel (ext_psel),
    .i_ext_rsp (ext_rsp), .o_apbactive (apbactive), .i_irq_src (irq_src),
    .o_irq (irq), .o_wdog_int (wdog_int), .o_wdog_rst (wdog_rst)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Every address bit shows up in the word
  function automatic logic [31:0] fill_word(input logic [5:0] a);
    return {2'b10, a, ~a, 2'b01, a, 4'h9, a ^ 6'h2a};
  endfunction

  // Big-endian lane order for each transfer size
  function automatic logic [31:0] expect_swap(input logic [31:0] d, input logic [2:0] size,
                                              input logic be);
    if (!be || size == 3'd0)
      return d;
    if (size == 3'd1)
      return {d[23:16], d[31:24], d[7:0], d[15:8]};
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
  endfunction

  function automatic logic [31:0] irq_vector(input irq_src_t s);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < 3; i++)
    begin
      v[2*i]     = s.uart_rx[i];   // rx and tx interleaved
      v[2*i + 1] = s.uart_tx[i];
      v[12 + i]  = s.uart_rxovr[i] | s.uart_txovr[i];
    end
    v[9]     = s.timer;
    v[10]    = s.dualtimer;
    v[23:16] = s.gpio;
    return v;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // ----------------------------------------------------------
  // External APB slave models, slots 12..15
  // ----------------------------------------------------------
  always @(posedge HCLK)
  begin
    for (int k = 0; k < N_EXT; k++)
    begin
      if (ext_psel[k])
      begin
        if (!apb.penable)
          wait_left[k] = plan_waits;          // Setup edge
        else if (!ext_rsp[k].pready)
          wait_left[k] = wait_left[k] - 1;
        else if (apb.pwrite && !plan_err)
          slv_mem[{k[1:0], apb.paddr[5:2]}] = apb.pwdata;  // Access ends
        ext_rsp[k].pready  <= !(apb.penable && ext_rsp[k].pready) && (wait_left[k] == 0);
        ext_rsp[k].prdata  <= slv_mem[{k[1:0], apb.paddr[5:2]}];
        ext_rsp[k].pslverr <= plan_err;
      end
      else
        ext_rsp[k] <= '{prdata: 32'hbad0_0000 | k, pready: 1'b1, pslverr: 1'b1};  // Misroute trap
    end
  end

  // ----------------------------------------------------------
  // One AHB transfer, address phase to completion
  // ----------------------------------------------------------
  task automatic ahb_transfer(input logic [15:0] addr, input logic wr, input logic [2:0] size,
                              input logic [31:0] wdata, input int waits, input logic err);
    logic [3:0] exp_sel;
    logic [5:0] idx;
    logic       ext;
    int         n;
    ext     = (addr[15:14] == 2'b11);
    exp_sel = ext ? (4'b0001 << addr[13:12]) : 4'b0000;
    idx     = {addr[13:12], addr[5:2]};
    @(posedge HCLK);
    plan_waits <= waits;
    plan_err   <= err;
    hsel       <= 1'b1;
    haddr      <= addr;
    htrans     <= 2'b10;  // NONSEQ
    hwrite     <= wr;
    hsize      <= size;
    @(negedge HCLK);      // Idle before acceptance
    compare_value("o_apbactive", apbactive, 1'b0);
    @(posedge HCLK);      // Accepted here
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwdata <= wdata;
    @(negedge HCLK);      // Setup cycle
    compare_value("o_ext_psel", ext_psel, exp_sel);
    compare_value("o_apb.penable", apb.penable, 1'b0);
    compare_value("o_apb.paddr", apb.paddr, addr[11:0]);
    compare_value("o_apb.pwrite", apb.pwrite, wr);
    compare_value("o_hreadyout", hreadyout, 1'b0);
    compare_value("o_apbactive", apbactive, 1'b1);
    if (wr)
      compare_value("o_apb.pwdata", apb.pwdata, expect_swap(wdata, size, big_endian));
    n = 0;
    while (!hreadyout && !hresp)
    begin
      @(negedge HCLK);
      n++;
      if (n > 40)
      begin
        $display("Timeout: transfer to address 0x%04h never completed", addr);
        $display("Some tests failed");
        $finish;
      end
    end
    compare_value("wait cycles", n, ext ? waits + 2 : 2);  // Setup plus access stretch
    if (ext && err)
    begin
      compare_value("o_hresp", hresp, 1'b1);
      compare_value("o_hreadyout", hreadyout, 1'b0);
      @(negedge HCLK);
      compare_value("o_hresp", hresp, 1'b1);
      compare_value("o_hreadyout", hreadyout, 1'b1);
      compare_value("o_apbactive", apbactive, 1'b1);
    end
    else
    begin
      compare_value("o_hresp", hresp, 1'b0);
      compare_value("o_apbactive", apbactive, 1'b1);  // Completing cycle
      if (!wr)
        compare_value("o_hrdata", hrdata,
                      ext ? expect_swap(ref_mem[idx], size, big_endian) : 32'h0);
      else if (ext)
        ref_mem[idx] = expect_swap(wdata, size, big_endian);
    end
  endtask

  task automatic irq_sync_test();
    irq_src_t    drv [0:47];
    irq_src_t    cur;
    logic [31:0] r;
    int          hold;
    cur  = '0;
    hold = 0;
    for (int c = 0; c < 48; c++)
    begin
      @(posedge HCLK);
      if (hold == 0)
      begin
        r    = next_random();
        cur  = r[$bits(irq_src_t)-1:0];
        hold = 2 + next_random() % 4;  // Held 2..5 cycles
      end
      hold--;
      irq_src <= cur;
      drv[c]  = cur;
      @(negedge HCLK);
      if (c >= 2)
      begin
        compare_value("o_irq", irq, irq_vector(drv[c-2]));
        compare_value("o_wdog_int", wdog_int, drv[c-2].wdog_int);
        compare_value("o_wdog_rst", wdog_rst, drv[c-2].wdog_rst);
      end
    end
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial
  begin
    logic [31:0] r;
    logic [15:0] a;
    int          afail;
    HRESETn = 1'b0;
    hsel = 1'b0;
    haddr = '0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hsize = 3'd0;
    hready = 1'b1;      // Single master keeps the bus ready
    hwdata = '0;
    big_endian = 1'b0;
    irq_src = '0;
    ext_rsp = '0;
    plan_waits = 0;
    plan_err = 1'b0;
    for (int i = 0; i < 64; i++)
    begin
      slv_mem[i] = fill_word(i[5:0]);
      ref_mem[i] = fill_word(i[5:0]);
    end
    repeat (8) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    compare_value("o_hreadyout", hreadyout, 1'b1);
    compare_value("o_hresp", hresp, 1'b0);
    compare_value("o_apbactive", apbactive, 1'b0);
    compare_value("o_ext_psel", ext_psel, 4'h0);
    compare_value("o_apb.penable", apb.penable, 1'b0);
    compare_value("o_irq", irq, 32'h0);
    compare_value("o_wdog_int", wdog_int, 1'b0);
    compare_value("o_wdog_rst", wdog_rst, 1'b0);
    repeat (16)           // Little-endian writes
    begin
      r = next_random();
      a = {2'b11, r[1:0], r[13:4], 2'b00};
      ahb_transfer(a, 1'b1, HSIZE_WORD, next_random(), r[17:16], 1'b0);
    end
    repeat (16)           // Little-endian reads
    begin
      r = next_random();
      a = {2'b11, r[1:0], r[13:4], 2'b00};
      ahb_transfer(a, 1'b0, HSIZE_WORD, 32'h0, r[17:16], 1'b0);
    end
    repeat (6)            // Unpopulated slots 0..11
    begin
      r = next_random();
      a = {4'(r[19:16] % 4'd12), r[13:4], 2'b00};
      ahb_transfer(a, 1'b0, HSIZE_WORD, 32'h0, 0, 1'b0);
    end
    @(posedge HCLK);
    big_endian <= 1'b1;
    repeat (30)           // Big-endian, all sizes
    begin
      r = next_random();
      a = {2'b11, r[1:0], r[13:4], 2'b00};
      ahb_transfer(a, r[20], 3'(r[19:18] % 2'd3), next_random(), r[17:16], 1'b0);
    end
    r = next_random();
    a = {2'b11, r[1:0], r[13:4], 2'b00};
    ahb_transfer(a, 1'b1, HSIZE_WORD, next_random(), 1, 1'b1);  // Write with slave error
    ahb_transfer(a, 1'b0, HSIZE_WORD, 32'h0, 0, 1'b1);
    ahb_transfer(a, 1'b0, HSIZE_WORD, 32'h0, 2, 1'b0);          // Memory untouched by the error
    irq_sync_test();
    afail = apb_subsys_top_i.ahb_apb_ctrl_i.apb_subsys_chk_i.fail_count;
    $display("Checks: %0d, value errors: %0d, assertion failures: %0d", checks, errors, afail);
    if (errors == 0 && afail == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: source/ahb_apb_ctrl.sv
// AHB-Lite to APB phase controller for one transfer at a time, instantiated by the subsystem top
`timescale 1ns/1ps

module ahb_apb_ctrl
  import apb_subsys_pkg::*;
(
  input  logic                HCLK,
  input  logic                HRESETn,
  input  logic                i_hsel,
  input  ahb_addr_t           i_haddr,
  input  logic [1:0]          i_htrans,
  input  logic                i_hwrite,
  input  logic                i_hready,
  input  logic [DW-1:0]       i_wdata_le,   // Write data after byte reordering
  input  apb_rsp_t            i_rsp,        // Response of the selected slot
  output apb_req_t            o_req,
  output logic                o_psel_any,
  output logic [REGION_W-1:0] o_region,
  output logic                o_accept,     // Address phase strobe for the swap logic
  output logic                o_hreadyout,
  output logic                o_hresp,
  output logic [DW-1:0]       o_rdata_le,
  output logic                o_apbactive
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_ERR1,   // HRESP high, HREADYOUT low
    ST_ERR2    // HRESP high, HREADYOUT high
  } state_t;

  state_t        state_q;
  state_t        state_nxt;
  ahb_addr_t     addr_q;
  logic          write_q;
  logic          done_q;      // Completing cycle of an OK transfer
  logic [DW-1:0] rdata_q;
  logic          access_end;

  // Valid NONSEQ/SEQ with the bus ready
  assign o_accept   = i_hsel & i_htrans[1] & i_hready;
  assign access_end = (state_q == ST_ACCESS) & i_rsp.pready;

  // ----------------------------------------------------------
  // Phase sequencing
  // ----------------------------------------------------------
  always_comb
  begin
    state_nxt = state_q;
    case (state_q)
      ST_IDLE:   if (o_accept) state_nxt = ST_SETUP;
      ST_SETUP:  state_nxt = ST_ACCESS;
      ST_ACCESS:
      begin
        if (i_rsp.pready)  // Access ends, error or not
          state_nxt = i_rsp.pslverr ? ST_ERR1 : ST_IDLE;
      end
      ST_ERR1:   state_nxt = ST_ERR2;
      ST_ERR2:   state_nxt = o_accept ? ST_SETUP : ST_IDLE;  // Back-to-back allowed
      default:   state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q <= ST_IDLE;
      addr_q  <= '0;
      write_q <= 1'b0;
      done_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_nxt;
      done_q  <= access_end & ~i_rsp.pslverr;
      if (o_accept)
      begin
        addr_q  <= i_haddr;   // Held through setup and access
        write_q <= i_hwrite;
      end
    end
  end

  // Read word captured as the access ends
  always_ff @(posedge HCLK)
  begin
    if (access_end)
      rdata_q <= i_rsp.prdata;
  end

  // ----------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------
  assign o_psel_any    = (state_q == ST_SETUP) | (state_q == ST_ACCESS);
  assign o_req.penable = (state_q == ST_ACCESS);
  assign o_req.paddr   = addr_q.offset;
  assign o_req.pwrite  = write_q;
  assign o_req.pwdata  = i_wdata_le;    // HWDATA is stable through the data phase
  assign o_region      = addr_q.region;

  assign o_hreadyout = (state_q == ST_IDLE) | (state_q == ST_ERR2);
  assign o_hresp     = (state_q == ST_ERR1) | (state_q == ST_ERR2);
  assign o_rdata_le  = rdata_q;
  // Active until the completing cycle inclusive
  assign o_apbactive = (state_q != ST_IDLE) | done_q;

endmodule

// File: source/apb_slot_mux.sv
// Region decode into external slot selects and response selection, between bridge and slots
`timescale 1ns/1ps

module apb_slot_mux
  import apb_subsys_pkg::*;
(
  input  logic                i_psel_any,    // Bridge is in setup or access
  input  logic [REGION_W-1:0] i_region,      // Registered HADDR[15:12]
  input  apb_rsp_t [N_EXT-1:0] i_ext_rsp,
  output logic [N_EXT-1:0]    o_ext_psel,
  output apb_rsp_t            o_rsp
);

  logic [N_EXT-1:0] ext_hit;   // One-hot, zero for slots 0..11
  logic             ext_any;

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------
  always_comb
  begin
    ext_hit = '0;
    for (int i = 0; i < N_EXT; i++)
    begin
      if (i_region == REGION_W'(EXT_BASE + i))
        ext_hit[i] = 1'b1;
    end
  end

  assign ext_any    = |ext_hit;
  assign o_ext_psel = ext_hit & {N_EXT{i_psel_any}};  // Only while a transfer runs

  // ----------------------------------------------------------
  // Response select
  // ----------------------------------------------------------
  always_comb
  begin
    // Unpopulated slot answers at once
    o_rsp.prdata  = '0;
    o_rsp.pready  = 1'b1;
    o_rsp.pslverr = 1'b0;
    if (ext_any)
    begin
      o_rsp = '0;
      for (int i = 0; i < N_EXT; i++)
      begin
        if (ext_hit[i])
          o_rsp = i_ext_rsp[i];   // External prdata, pready, pslverr
      end
    end
  end

endmodule

// File: source/apb_subsys_pkg.sv
// Shared widths, slot map, interrupt positions and bus structs; imported by every subsystem RTL file
package apb_subsys_pkg;

  // ----------------------------------------------------------
  // Bus widths and slot map
  // ----------------------------------------------------------
  localparam int AHB_AW   = 16;  // AHB address bits seen by the bridge
  localparam int DW       = 32;
  localparam int APB_AW   = 12;  // Offset inside one slot
  localparam int REGION_W = 4;   // HADDR[15:12]
  localparam int N_EXT    = 4;   // Slots 12..15 go off-chip
  localparam int EXT_BASE = 12;

  // ----------------------------------------------------------
  // Interrupt vector layout
  // ----------------------------------------------------------
  localparam int IRQ_W         = 32;
  localparam int IRQ_UART_RX0  = 0;   // rx/tx interleaved, stride 2
  localparam int IRQ_UART_TX0  = 1;
  localparam int IRQ_TIMER     = 9;
  localparam int IRQ_DUALTIMER = 10;
  localparam int IRQ_UART_OVF0 = 12;  // Overflow 0..2 at 12..14
  localparam int IRQ_GPIO_LSB  = 16;  // 8 GPIO lines at 16..23

  // AHB size codes
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  typedef struct packed {
    logic [REGION_W-1:0] region;  // Slot number
    logic [APB_AW-1:0]   offset;  // Becomes PADDR
  } ahb_addr_t;

  // Request driven to every slot, only PSEL differs
  typedef struct packed {
    logic [APB_AW-1:0] paddr;
    logic              pwrite;
    logic [DW-1:0]     pwdata;
    logic              penable;
  } apb_req_t;

  typedef struct packed {
    logic [DW-1:0] prdata;
    logic          pready;
    logic          pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic half_swap;  // Bytes within each halfword
    logic word_swap;  // Halfwords within the word
  } swap_ctl_t;

  // Raw peripheral interrupt lines, foreign clock domain
  typedef struct packed {
    logic [2:0] uart_rx;
    logic [2:0] uart_tx;
    logic [2:0] uart_rxovr;
    logic [2:0] uart_txovr;
    logic       timer;
    logic       dualtimer;
    logic [7:0] gpio;
    logic       wdog_int;
    logic       wdog_rst;
  } irq_src_t;

endpackage

// File: source/apb_subsys_top.sv
// AHB-Lite slave to 16-slot APB subsystem top level, connecting bridge, swap, mux and interrupts
`timescale 1ns/1ps

module apb_subsys_top
  import apb_subsys_pkg::*;
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  // AHB-Lite slave port
  input  logic                 i_hsel,
  input  logic [AHB_AW-1:0]    i_haddr,
  input  logic [1:0]           i_htrans,
  input  logic                 i_hwrite,
  input  logic [2:0]           i_hsize,
  input  logic                 i_hready,
  input  logic [DW-1:0]        i_hwdata,
  output logic                 o_hreadyout,
  output logic [DW-1:0]        o_hrdata,
  output logic                 o_hresp,
  input  logic                 i_big_endian,
  // External APB slots 12..15
  output apb_req_t             o_apb,
  output logic [N_EXT-1:0]     o_ext_psel,
  input  apb_rsp_t [N_EXT-1:0] i_ext_rsp,
  output logic                 o_apbactive,
  // Interrupts
  input  irq_src_t             i_irq_src,
  output logic [IRQ_W-1:0]     o_irq,
  output logic                 o_wdog_int,
  output logic                 o_wdog_rst
);

  logic                psel_any;
  logic [REGION_W-1:0] region;
  logic                accept;
  logic [DW-1:0]       wdata_le;   // Swapped HWDATA
  logic [DW-1:0]       rdata_le;   // Captured PRDATA
  apb_rsp_t            rsp_mux;

  ahb_apb_ctrl ahb_apb_ctrl_i (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hready    (i_hready),
    .i_wdata_le  (wdata_le),
    .i_rsp       (rsp_mux),
    .o_req       (o_apb),
    .o_psel_any  (psel_any),
    .o_region    (region),
    .o_accept    (accept),
    .o_hreadyout (o_hreadyout),
    .o_hresp     (o_hresp),
    .o_rdata_le  (rdata_le),
    .o_apbactive (o_apbactive)
  );

  endian_swap endian_swap_i (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_big_endian (i_big_endian),
    .i_accept     (accept),
    .i_hsize      (i_hsize),
    .i_hwdata     (i_hwdata),
    .i_rdata_le   (rdata_le),
    .o_wdata_le   (wdata_le),
    .o_hrdata     (o_hrdata)
  );

  apb_slot_mux apb_slot_mux_i (
    .i_psel_any (psel_any),
    .i_region   (region),
    .i_ext_rsp  (i_ext_rsp),
    .o_ext_psel (o_ext_psel),
    .o_rsp      (rsp_mux)
  );

  irq_collect irq_collect_i (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .i_src      (i_irq_src),
    .o_irq      (o_irq),
    .o_wdog_int (o_wdog_int),
    .o_wdog_rst (o_wdog_rst)
  );

endmodule

// File: source/endian_swap.sv
// Big-endian byte reordering of AHB write and read data, used between the AHB pins and the bridge
`timescale 1ns/1ps

module endian_swap
  import apb_subsys_pkg::*;
(
  input  logic          HCLK,
  input  logic          HRESETn,
  input  logic          i_big_endian,  // Level strap
  input  logic          i_accept,      // Transfer accepted this cycle
  input  logic [2:0]    i_hsize,
  input  logic [DW-1:0] i_hwdata,
  input  logic [DW-1:0] i_rdata_le,
  output logic [DW-1:0] o_wdata_le,
  output logic [DW-1:0] o_hrdata
);

  swap_ctl_t swap_nxt;
  swap_ctl_t swap_q;    // Valid for the whole data phase

  // Bytes within halfwords first, then halfwords
  function automatic logic [DW-1:0] reorder(input swap_ctl_t ctl, input logic [DW-1:0] d);
    logic [DW-1:0] h;
    h = ctl.half_swap ? {d[23:16], d[31:24], d[7:0], d[15:8]} : d;
    return ctl.word_swap ? {h[15:0], h[31:16]} : h;
  endfunction

  always_comb
  begin
    swap_nxt = '0;     // Little-endian mode
    if (i_big_endian)
    begin
      case (i_hsize)
        HSIZE_BYTE: swap_nxt = '0;
        HSIZE_HALF: swap_nxt.half_swap = 1'b1;
        HSIZE_WORD: swap_nxt = '{half_swap: 1'b1, word_swap: 1'b1};
        default:    swap_nxt = '0;
      endcase
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      swap_q <= '0;
    else if (i_accept)
      swap_q <= swap_nxt;   // Address phase sample
  end

  assign o_wdata_le = reorder(swap_q, i_hwdata);
  assign o_hrdata   = reorder(swap_q, i_rdata_le);  // Same reordering back

endmodule

// File: source/irq_collect.sv
// Two-flop HCLK synchronisers for peripheral interrupts and assembly of the 32-bit vector
`timescale 1ns/1ps

module irq_collect
  import apb_subsys_pkg::*;
(
  input  logic             HCLK,
  input  logic             HRESETn,
  input  irq_src_t         i_src,      // Asynchronous to HCLK
  output logic [IRQ_W-1:0] o_irq,
  output logic             o_wdog_int,
  output logic             o_wdog_rst
);

  // Lines after overrun merging
  typedef struct packed {
    logic [2:0] uart_rx;
    logic [2:0] uart_tx;
    logic [2:0] uart_ovf;
    logic       timer;
    logic       dualtimer;
    logic [7:0] gpio;
    logic       wdog_int;
    logic       wdog_rst;
  } irq_line_t;

  irq_line_t raw;
  irq_line_t meta_q;   // First stage, may go metastable
  irq_line_t sync_q;

  // ----------------------------------------------------------
  // Merge and synchronise
  // ----------------------------------------------------------
  assign raw.uart_rx   = i_src.uart_rx;
  assign raw.uart_tx   = i_src.uart_tx;
  assign raw.uart_ovf  = i_src.uart_rxovr | i_src.uart_txovr;  // Before the flops
  assign raw.timer     = i_src.timer;
  assign raw.dualtimer = i_src.dualtimer;
  assign raw.gpio      = i_src.gpio;
  assign raw.wdog_int  = i_src.wdog_int;
  assign raw.wdog_rst  = i_src.wdog_rst;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      meta_q <= '0;
      sync_q <= '0;
    end
    else
    begin
      meta_q <= raw;
      sync_q <= meta_q;   // Two edges of latency
    end
  end

  // ----------------------------------------------------------
  // Vector placement, unused bits stay zero
  // ----------------------------------------------------------
  always_comb
  begin
    o_irq = '0;
    for (int i = 0; i < 3; i++)
    begin
      o_irq[IRQ_UART_RX0 + 2*i] = sync_q.uart_rx[i];
      o_irq[IRQ_UART_TX0 + 2*i] = sync_q.uart_tx[i];
      o_irq[IRQ_UART_OVF0 + i]  = sync_q.uart_ovf[i];
    end
    o_irq[IRQ_TIMER]         = sync_q.timer;
    o_irq[IRQ_DUALTIMER]     = sync_q.dualtimer;
    o_irq[IRQ_GPIO_LSB +: 8] = sync_q.gpio;
  end

  assign o_wdog_int = sync_q.wdog_int;  // NMI source
  assign o_wdog_rst = sync_q.wdog_rst;  // To reset generator

endmodule
